/* common/qcore_defs.svh */
`ifndef QCORE_DEFS_SVH
`define QCORE_DEFS_SVH

// Word and address widths
`define QCORE_INSTR_W    40
`define QCORE_DATA_W     32
`define QCORE_REG_AW     4
`define QCORE_REG_NUM    16  // 2**QCORE_REG_AW
`define QCORE_PMEM_AW    8
`define QCORE_DMEM_AW    8
`define QCORE_PORT_AW    4
`define QCORE_IMM_W      16

//////////////////////////////////////////////////
// Instruction field positions
`define QCORE_F_HDR      39:37
`define QCORE_F_COND     36:34
`define QCORE_F_ALU_OP   33:31
`define QCORE_F_IMM_SEL  30
`define QCORE_F_FLAG_WE  29
`define QCORE_F_RD       28:25
`define QCORE_F_RS_A     24:21
`define QCORE_F_RS_B     20:17
`define QCORE_F_IMM      15:0     // Bit 16 is spare

`endif

/* common/qcore_pkg.sv */
`include "qcore_defs.svh"

package qcore_pkg;

   typedef logic [`QCORE_INSTR_W-1:0] instr_t;
   typedef logic [`QCORE_DATA_W-1:0]  word_t;
   typedef logic [`QCORE_REG_AW-1:0]  reg_addr_t;
   typedef logic [`QCORE_PMEM_AW-1:0] pc_t;
   typedef logic [`QCORE_DMEM_AW-1:0] dmem_addr_t;
   typedef logic [`QCORE_PORT_AW-1:0] port_addr_t;

   // Opcode, all zero is NOP
   typedef enum logic [2:0] {
      NOP     = 3'd0,
      REG_WR  = 3'd1,  // rd <= ALU
      REG_LD  = 3'd2,  // rd <= dmem[rsA + imm]
      MEM_WR  = 3'd3,  // dmem[rsA + imm] <= rsB
      PORT_WR = 3'd4,  // port[rd] <= ALU
      BRANCH  = 3'd5   // PC <= imm
   } hdr_e;

   typedef enum logic [2:0] {
      ALWAYS, EQ, LT, NZ, NS, FLAG, NFLAG, NEVER
   } cond_e;

   typedef enum logic [2:0] {
      ADD, SUB, AND, OR, XOR, SHL, SHR, PASS_B
   } alu_op_e;

endpackage

/* core/qcore_fetch.sv */
`timescale 1ns/1ps

module qcore_fetch (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              restart_i,
   input  logic              en_i,
   input  logic              stall_i,
   input  logic              branch_i,
   input  qcore_pkg::pc_t    target_i,
   input  qcore_pkg::instr_t pmem_dt_i,
   output qcore_pkg::pc_t    pmem_addr_o,
   output logic              pmem_en_o,
   output qcore_pkg::instr_t instr_o
);

   qcore_pkg::pc_t    pc;
   qcore_pkg::instr_t ir;
   logic              r_branch;   // Branch taken last slot
   logic              r_mem_rst;  // First read after reset or restart
   logic              advance;

   assign advance = en_i & ~stall_i;

   // Memory output is stale on the first cycle, and the two slots after a
   // taken branch hold words already in flight
   always_ff @(posedge clk_i) begin
      if (!rst_ni || restart_i) begin
         pc        <= '0;
         ir        <= '0;  // NOP
         r_branch  <= 1'b0;
         r_mem_rst <= 1'b1;
      end else begin
         if (en_i) r_mem_rst <= 1'b0;  // Held while frozen
         if (advance) begin
            pc       <= branch_i ? target_i : pc + 1'b1;
            r_branch <= branch_i;
            if (branch_i || r_branch || r_mem_rst)
               ir <= '0;
            else
               ir <= pmem_dt_i;
         end
      end
   end

   assign pmem_addr_o = pc;
   assign pmem_en_o   = advance | r_mem_rst;  // Memory output holds otherwise
   assign instr_o     = ir;

endmodule

/* core/qcore_decode.sv */
`timescale 1ns/1ps
`include "qcore_defs.svh"

module qcore_decode (
   input  logic                 clk_i,
   input  logic                 rst_ni,
   input  logic                 restart_i,
   input  logic                 en_i,
   input  logic                 stall_i,
   input  qcore_pkg::instr_t    instr_i,
   input  logic                 flag_i,
   input  logic                 z_i,
   input  logic                 s_i,
   input  qcore_pkg::word_t     rs_a_dt_i,
   input  qcore_pkg::word_t     rs_b_dt_i,
   output logic                 branch_o,
   output qcore_pkg::pc_t       target_o,
   output qcore_pkg::reg_addr_t rs_a_addr_o,
   output qcore_pkg::reg_addr_t rs_b_addr_o,
   output logic                 rs_a_used_o,
   output logic                 rs_b_used_o,
   output logic                 cond_used_o,
   output qcore_pkg::hdr_e      x1_hdr_o,
   output qcore_pkg::alu_op_e   x1_alu_op_o,
   output logic                 x1_flag_we_o,
   output qcore_pkg::reg_addr_t x1_rd_o,
   output qcore_pkg::word_t     x1_a_o,
   output qcore_pkg::word_t     x1_b_o,
   output qcore_pkg::word_t     x1_st_dt_o,
   output qcore_pkg::word_t     x1_imm_o
);

   qcore_pkg::hdr_e    hdr;
   qcore_pkg::cond_e   cond;
   qcore_pkg::alu_op_e alu_op;
   qcore_pkg::word_t   imm;
   logic imm_sel, flag_we, cond_ok, is_cond, exec_ok, alu_use, is_mem;

   //////////////////////////////////////////////////
   // Field decode
   assign hdr     = qcore_pkg::hdr_e'(instr_i[`QCORE_F_HDR]);
   assign cond    = qcore_pkg::cond_e'(instr_i[`QCORE_F_COND]);
   assign alu_op  = qcore_pkg::alu_op_e'(instr_i[`QCORE_F_ALU_OP]);
   assign imm_sel = instr_i[`QCORE_F_IMM_SEL];
   assign flag_we = instr_i[`QCORE_F_FLAG_WE];
   assign imm     = {{(`QCORE_DATA_W-`QCORE_IMM_W){instr_i[`QCORE_IMM_W-1]}},
                     instr_i[`QCORE_F_IMM]};

   assign rs_a_addr_o = instr_i[`QCORE_F_RS_A];
   assign rs_b_addr_o = instr_i[`QCORE_F_RS_B];

   // ALU runs for writes and for any flag update
   assign alu_use = (hdr == qcore_pkg::REG_WR) | (hdr == qcore_pkg::PORT_WR) | flag_we;
   assign is_mem  = (hdr == qcore_pkg::REG_LD) | (hdr == qcore_pkg::MEM_WR);
   assign rs_a_used_o = (alu_use & (alu_op != qcore_pkg::PASS_B)) | is_mem;
   assign rs_b_used_o = (alu_use & ~imm_sel) | (hdr == qcore_pkg::MEM_WR);

   //////////////////////////////////////////////////
   // Condition
   always_comb begin
      unique case (cond)
         qcore_pkg::ALWAYS : cond_ok = 1'b1;
         qcore_pkg::EQ     : cond_ok = z_i;
         qcore_pkg::LT     : cond_ok = s_i;
         qcore_pkg::NZ     : cond_ok = ~z_i;
         qcore_pkg::NS     : cond_ok = ~s_i;
         qcore_pkg::FLAG   : cond_ok = flag_i;
         qcore_pkg::NFLAG  : cond_ok = ~flag_i;
         qcore_pkg::NEVER  : cond_ok = 1'b0;
      endcase
   end

   assign is_cond = (hdr == qcore_pkg::REG_WR) | (hdr == qcore_pkg::MEM_WR) |
                    (hdr == qcore_pkg::PORT_WR) | (hdr == qcore_pkg::BRANCH);
   assign exec_ok = cond_ok | ~is_cond;
   // Only Z and S come from the pipeline
   assign cond_used_o = is_cond & ((cond == qcore_pkg::EQ) | (cond == qcore_pkg::LT) |
                                   (cond == qcore_pkg::NZ) | (cond == qcore_pkg::NS));

   assign branch_o = (hdr == qcore_pkg::BRANCH) & exec_ok & ~stall_i;
   assign target_o = qcore_pkg::pc_t'(instr_i[`QCORE_F_IMM]);

   //////////////////////////////////////////////////
   // X1 pipeline register
   always_ff @(posedge clk_i) begin
      if (!rst_ni || restart_i) begin
         x1_hdr_o     <= qcore_pkg::NOP;
         x1_flag_we_o <= 1'b0;
      end else if (en_i) begin
         if (stall_i) begin  // Bubble
            x1_hdr_o     <= qcore_pkg::NOP;
            x1_flag_we_o <= 1'b0;
         end else begin
            x1_hdr_o     <= exec_ok ? hdr : qcore_pkg::NOP;
            x1_flag_we_o <= flag_we;  // Kept on failed condition
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (en_i && !stall_i) begin
         x1_alu_op_o <= alu_op;
         x1_rd_o     <= instr_i[`QCORE_F_RD];
         x1_a_o      <= rs_a_dt_i;
         x1_b_o      <= imm_sel ? imm : rs_b_dt_i;
         x1_st_dt_o  <= rs_b_dt_i;
         x1_imm_o    <= imm;
      end
   end

endmodule

/* core/qcore_hazard.sv */
`timescale 1ns/1ps

module qcore_hazard (
   input  qcore_pkg::reg_addr_t rs_a_addr_i,
   input  qcore_pkg::reg_addr_t rs_b_addr_i,
   input  logic                 rs_a_used_i,
   input  logic                 rs_b_used_i,
   input  logic                 cond_used_i,
   input  qcore_pkg::reg_addr_t x1_rd_i,
   input  logic                 x1_rd_we_i,
   input  qcore_pkg::reg_addr_t x2_rd_i,
   input  logic                 x2_rd_we_i,
   input  logic                 x1_flag_we_i,
   output logic                 stall_o
);

   logic hz_a, hz_b, hz_flag;

   // Source A against X1 and X2 destinations
   assign hz_a = rs_a_used_i &
                 ((x1_rd_we_i & (x1_rd_i == rs_a_addr_i)) |
                  (x2_rd_we_i & (x2_rd_i == rs_a_addr_i)));

   assign hz_b = rs_b_used_i &
                 ((x1_rd_we_i & (x1_rd_i == rs_b_addr_i)) |
                  (x2_rd_we_i & (x2_rd_i == rs_b_addr_i)));

   // Flags register at the end of X1, so only X1 is in the way
   assign hz_flag = cond_used_i & x1_flag_we_i;

   assign stall_o = hz_a | hz_b | hz_flag;

endmodule

/* core/qcore_reg_bank.sv */
`timescale 1ns/1ps
`include "qcore_defs.svh"

module qcore_reg_bank (
   input  logic                 clk_i,
   input  logic                 rst_ni,
   input  logic                 restart_i,
   input  qcore_pkg::reg_addr_t rs_a_addr_i,
   input  qcore_pkg::reg_addr_t rs_b_addr_i,
   input  logic                 we_i,
   input  qcore_pkg::reg_addr_t w_addr_i,
   input  qcore_pkg::word_t     w_dt_i,
   output qcore_pkg::word_t     rs_a_dt_o,
   output qcore_pkg::word_t     rs_b_dt_o
);

   qcore_pkg::word_t regs [`QCORE_REG_NUM];

   always_ff @(posedge clk_i) begin
      if (!rst_ni || restart_i)
         regs <= '{default: '0};
      else if (we_i)
         regs[w_addr_i] <= w_dt_i;
   end

   // Write-through so decode sees the X2 result now
   assign rs_a_dt_o = (we_i && w_addr_i == rs_a_addr_i) ? w_dt_i : regs[rs_a_addr_i];
   assign rs_b_dt_o = (we_i && w_addr_i == rs_b_addr_i) ? w_dt_i : regs[rs_b_addr_i];

endmodule

/* core/qcore_execute.sv */
`timescale 1ns/1ps

module qcore_execute (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  restart_i,
   input  logic                  en_i,
   input  qcore_pkg::hdr_e       x1_hdr_i,
   input  qcore_pkg::alu_op_e    x1_alu_op_i,
   input  logic                  x1_flag_we_i,
   input  qcore_pkg::reg_addr_t  x1_rd_i,
   input  qcore_pkg::word_t      x1_a_i,
   input  qcore_pkg::word_t      x1_b_i,
   input  qcore_pkg::word_t      x1_st_dt_i,
   input  qcore_pkg::word_t      x1_imm_i,
   input  qcore_pkg::word_t      dmem_r_dt_i,
   output logic                  dmem_we_o,
   output qcore_pkg::dmem_addr_t dmem_addr_o,
   output qcore_pkg::word_t      dmem_w_dt_o,
   output logic                  z_o,
   output logic                  s_o,
   output logic                  x1_rd_we_o,
   output qcore_pkg::reg_addr_t  x2_rd_o,
   output logic                  x2_rd_we_o,
   output logic                  x1_flag_we_o,
   output logic                  wb_we_o,
   output qcore_pkg::reg_addr_t  wb_addr_o,
   output qcore_pkg::word_t      wb_dt_o,
   output logic                  port_we_o,
   output qcore_pkg::port_addr_t port_addr_o,
   output qcore_pkg::word_t      port_dt_o
);

   qcore_pkg::word_t      alu_dt, mem_sum, x2_alu_dt;
   qcore_pkg::dmem_addr_t x1_mem_addr, x2_mem_addr;
   qcore_pkg::hdr_e       x2_hdr;

   //////////////////////////////////////////////////
   // X1
   always_comb begin
      unique case (x1_alu_op_i)
         qcore_pkg::ADD    : alu_dt = x1_a_i + x1_b_i;
         qcore_pkg::SUB    : alu_dt = x1_a_i - x1_b_i;
         qcore_pkg::AND    : alu_dt = x1_a_i & x1_b_i;
         qcore_pkg::OR     : alu_dt = x1_a_i | x1_b_i;
         qcore_pkg::XOR    : alu_dt = x1_a_i ^ x1_b_i;
         qcore_pkg::SHL    : alu_dt = x1_a_i << x1_b_i[4:0];
         qcore_pkg::SHR    : alu_dt = x1_a_i >> x1_b_i[4:0];
         qcore_pkg::PASS_B : alu_dt = x1_b_i;
      endcase
   end

   assign mem_sum     = x1_a_i + x1_imm_i;
   assign x1_mem_addr = qcore_pkg::dmem_addr_t'(mem_sum);

   assign x1_rd_we_o   = (x1_hdr_i == qcore_pkg::REG_WR) | (x1_hdr_i == qcore_pkg::REG_LD);
   assign x1_flag_we_o = x1_flag_we_i;

   always_ff @(posedge clk_i) begin
      if (!rst_ni || restart_i) begin
         z_o <= 1'b0;
         s_o <= 1'b0;
      end else if (en_i && x1_flag_we_i) begin
         z_o <= (alu_dt == '0);
         s_o <= alu_dt[31];  // Sign
      end
   end

   //////////////////////////////////////////////////
   // X2 pipeline register
   always_ff @(posedge clk_i) begin
      if (!rst_ni || restart_i)
         x2_hdr <= qcore_pkg::NOP;
      else if (en_i)
         x2_hdr <= x1_hdr_i;
   end

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         x2_rd_o     <= x1_rd_i;
         x2_alu_dt   <= alu_dt;
         x2_mem_addr <= x1_mem_addr;
      end
   end

   assign x2_rd_we_o = (x2_hdr == qcore_pkg::REG_WR) | (x2_hdr == qcore_pkg::REG_LD);

   // Frozen, the address falls back to the X2 load so its data stays valid
   assign dmem_addr_o = en_i ? x1_mem_addr : x2_mem_addr;
   assign dmem_we_o   = en_i & (x1_hdr_i == qcore_pkg::MEM_WR);
   assign dmem_w_dt_o = x1_st_dt_i;

   assign wb_we_o   = en_i & x2_rd_we_o;
   assign wb_addr_o = x2_rd_o;
   assign wb_dt_o   = (x2_hdr == qcore_pkg::REG_LD) ? dmem_r_dt_i : x2_alu_dt;

   assign port_we_o   = en_i & (x2_hdr == qcore_pkg::PORT_WR);
   assign port_addr_o = qcore_pkg::port_addr_t'(x2_rd_o);  // rd names the port
   assign port_dt_o   = x2_alu_dt;

endmodule

/* verilog/qcore_cpu.sv */
`timescale 1ns/1ps

module qcore_cpu (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  restart_i,
   input  logic                  en_i,
   input  logic                  flag_i,
   // Program memory
   output qcore_pkg::pc_t        pmem_addr_o,
   output logic                  pmem_en_o,
   input  qcore_pkg::instr_t     pmem_dt_i,
   // Data memory
   output logic                  dmem_we_o,
   output qcore_pkg::dmem_addr_t dmem_addr_o,
   output qcore_pkg::word_t      dmem_w_dt_o,
   input  qcore_pkg::word_t      dmem_r_dt_i,
   // Output ports
   output logic                  port_we_o,
   output qcore_pkg::port_addr_t port_addr_o,
   output qcore_pkg::word_t      port_dt_o
);

   qcore_pkg::instr_t    instr;
   qcore_pkg::pc_t       target;
   logic                 branch, stall;
   qcore_pkg::reg_addr_t rs_a_addr, rs_b_addr;
   logic                 rs_a_used, rs_b_used, cond_used;
   qcore_pkg::word_t     rs_a_dt, rs_b_dt;
   logic                 z_flag, s_flag;

   // Decode to X1
   qcore_pkg::hdr_e      x1_hdr;
   qcore_pkg::alu_op_e   x1_alu_op;
   logic                 x1_flag_we;
   qcore_pkg::reg_addr_t x1_rd;
   qcore_pkg::word_t     x1_a, x1_b, x1_st_dt, x1_imm;

   // In-flight destinations for the hazard unit
   logic                 x1_rd_we, x2_rd_we, x1_flag_we_hz;
   qcore_pkg::reg_addr_t x2_rd;

   // Write-back
   logic                 wb_we;
   qcore_pkg::reg_addr_t wb_addr;
   qcore_pkg::word_t     wb_dt;

   qcore_fetch u_fetch (
      .clk_i, .rst_ni, .restart_i, .en_i,
      .stall_i (stall), .branch_i (branch), .target_i (target),
      .pmem_dt_i, .pmem_addr_o, .pmem_en_o,
      .instr_o (instr)
   );

   qcore_decode u_decode (
      .clk_i, .rst_ni, .restart_i, .en_i, .flag_i,
      .stall_i (stall), .instr_i (instr), .z_i (z_flag), .s_i (s_flag),
      .rs_a_dt_i (rs_a_dt), .rs_b_dt_i (rs_b_dt),
      .branch_o (branch), .target_o (target),
      .rs_a_addr_o (rs_a_addr), .rs_b_addr_o (rs_b_addr),
      .rs_a_used_o (rs_a_used), .rs_b_used_o (rs_b_used), .cond_used_o (cond_used),
      .x1_hdr_o (x1_hdr), .x1_alu_op_o (x1_alu_op), .x1_flag_we_o (x1_flag_we),
      .x1_rd_o (x1_rd), .x1_a_o (x1_a), .x1_b_o (x1_b),
      .x1_st_dt_o (x1_st_dt), .x1_imm_o (x1_imm)
   );

   qcore_hazard u_hazard (
      .rs_a_addr_i (rs_a_addr), .rs_b_addr_i (rs_b_addr),
      .rs_a_used_i (rs_a_used), .rs_b_used_i (rs_b_used), .cond_used_i (cond_used),
      .x1_rd_i (x1_rd), .x1_rd_we_i (x1_rd_we),
      .x2_rd_i (x2_rd), .x2_rd_we_i (x2_rd_we),
      .x1_flag_we_i (x1_flag_we_hz),
      .stall_o (stall)
   );

   qcore_reg_bank u_reg_bank (
      .clk_i, .rst_ni, .restart_i,
      .rs_a_addr_i (rs_a_addr), .rs_b_addr_i (rs_b_addr),
      .we_i (wb_we), .w_addr_i (wb_addr), .w_dt_i (wb_dt),
      .rs_a_dt_o (rs_a_dt), .rs_b_dt_o (rs_b_dt)
   );

   qcore_execute u_execute (
      .clk_i, .rst_ni, .restart_i, .en_i,
      .x1_hdr_i (x1_hdr), .x1_alu_op_i (x1_alu_op), .x1_flag_we_i (x1_flag_we),
      .x1_rd_i (x1_rd), .x1_a_i (x1_a), .x1_b_i (x1_b),
      .x1_st_dt_i (x1_st_dt), .x1_imm_i (x1_imm), .dmem_r_dt_i,
      .dmem_we_o, .dmem_addr_o, .dmem_w_dt_o,
      .z_o (z_flag), .s_o (s_flag),
      .x1_rd_we_o (x1_rd_we), .x2_rd_o (x2_rd), .x2_rd_we_o (x2_rd_we),
      .x1_flag_we_o (x1_flag_we_hz),
      .wb_we_o (wb_we), .wb_addr_o (wb_addr), .wb_dt_o (wb_dt),
      .port_we_o, .port_addr_o, .port_dt_o
   );

endmodule

/* sim/qcore_ref.svh */
`ifndef QCORE_REF_SVH
`define QCORE_REF_SVH

//////////////////////////////////////////////////
// Program building

function automatic qcore_pkg::instr_t encode(
   input qcore_pkg::hdr_e h, input qcore_pkg::cond_e c, input qcore_pkg::alu_op_e op,
   input logic isel, input logic fw, input qcore_pkg::reg_addr_t rd,
   input qcore_pkg::reg_addr_t ra, input qcore_pkg::reg_addr_t rb, input logic [15:0] imm);
   qcore_pkg::instr_t w;
   w = '0;
   w[`QCORE_F_HDR]     = h;
   w[`QCORE_F_COND]    = c;
   w[`QCORE_F_ALU_OP]  = op;
   w[`QCORE_F_IMM_SEL] = isel;
   w[`QCORE_F_FLAG_WE] = fw;
   w[`QCORE_F_RD]      = rd;
   w[`QCORE_F_RS_A]    = ra;
   w[`QCORE_F_RS_B]    = rb;
   w[`QCORE_F_IMM]     = imm;
   return w;
endfunction

function automatic void emit(input qcore_pkg::instr_t w);
   prog[8'(plen)] = w;
   plen++;
endfunction

// rd <= sign-extended immediate
function automatic void load_imm(input qcore_pkg::reg_addr_t rd, input logic [15:0] v);
   emit(encode(qcore_pkg::REG_WR, qcore_pkg::ALWAYS, qcore_pkg::PASS_B, 1'b1, 1'b0,
               rd, 4'd0, 4'd0, v));
endfunction

function automatic void halt_here();
   emit(encode(qcore_pkg::BRANCH, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0, 1'b0,
               4'd0, 4'd0, 4'd0, 16'(plen)));
endfunction

// Every empty slot is a branch to itself
function automatic void new_prog();
   for (int i = 0; i < 256; i++)
      prog[8'(i)] = encode(qcore_pkg::BRANCH, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0,
                           1'b0, 4'd0, 4'd0, 4'd0, 16'(i));
   plen = 0;
endfunction

//////////////////////////////////////////////////
// Instruction-level interpreter, returns instructions executed

function automatic int run_ref(input logic flag);
   qcore_pkg::word_t  regs [16];
   qcore_pkg::word_t  a, b, res, imm;
   qcore_pkg::instr_t w;
   qcore_pkg::pc_t    pc;
   logic [2:0]        h;
   logic              z, s, ok;
   int                steps;
   regs  = '{default: '0};
   pc    = '0;
   z     = 1'b0;
   s     = 1'b0;
   steps = 0;
   while (steps < 4000) begin
      w   = prog[pc];
      h   = w[`QCORE_F_HDR];
      imm = {{16{w[15]}}, w[15:0]};
      a   = regs[w[`QCORE_F_RS_A]];
      b   = w[`QCORE_F_IMM_SEL] ? imm : regs[w[`QCORE_F_RS_B]];
      case (w[`QCORE_F_ALU_OP])
         3'd0: res = a + b;
         3'd1: res = a - b;
         3'd2: res = a & b;
         3'd3: res = a | b;
         3'd4: res = a ^ b;
         3'd5: res = a << b[4:0];
         3'd6: res = a >> b[4:0];
         default: res = b;
      endcase
      case (w[`QCORE_F_COND])
         3'd0: ok = 1'b1;
         3'd1: ok = z;
         3'd2: ok = s;
         3'd3: ok = !z;
         3'd4: ok = !s;
         3'd5: ok = flag;
         3'd6: ok = !flag;
         default: ok = 1'b0;
      endcase
      steps++;
      if (h == qcore_pkg::BRANCH && ok && w[7:0] == pc)
         break;  // HALT loop
      if (h == qcore_pkg::REG_WR && ok)
         regs[w[`QCORE_F_RD]] = res;
      if (h == qcore_pkg::REG_LD)  // Never conditional
         regs[w[`QCORE_F_RD]] = ref_dmem[8'(a + imm)];
      if (h == qcore_pkg::MEM_WR && ok) begin
         ref_dmem[8'(a + imm)] = regs[w[`QCORE_F_RS_B]];
         exp_st_a.push_back(8'(a + imm));
         exp_st_d.push_back(regs[w[`QCORE_F_RS_B]]);
      end
      if (h == qcore_pkg::PORT_WR && ok) begin
         exp_port_a.push_back(w[`QCORE_F_RD]);
         exp_port_d.push_back(res);
      end
      if (w[`QCORE_F_FLAG_WE]) begin  // Even when the condition failed
         z = (res == '0);
         s = res[31];
      end
      pc = (h == qcore_pkg::BRANCH && ok) ? w[7:0] : pc + 8'd1;
   end
   return steps;
endfunction

`endif

/* sim/qcore_tb.sv */
`timescale 1ns/1ps
`include "qcore_defs.svh"

module qcore_tb;

   logic clk_i, rst_ni, restart_i, en_i, flag_i;
   qcore_pkg::instr_t     pmem_dt_i;
   qcore_pkg::word_t      dmem_r_dt_i, dmem_w_dt_o, port_dt_o;
   qcore_pkg::pc_t        pmem_addr_o;
   qcore_pkg::dmem_addr_t dmem_addr_o;
   qcore_pkg::port_addr_t port_addr_o;
   logic pmem_en_o, dmem_we_o, port_we_o;

   qcore_pkg::instr_t     prog [256];
   qcore_pkg::word_t      dmem [256];
   qcore_pkg::word_t      ref_dmem [256];
   qcore_pkg::port_addr_t exp_port_a [$];
   qcore_pkg::word_t      exp_port_d [$];
   qcore_pkg::dmem_addr_t exp_st_a [$];
   qcore_pkg::word_t      exp_st_d [$];
   int    plen, cyc, budget, en_left;
   logic  checking, en_rand;
   string test_name;

`include "qcore_ref.svh"

   qcore_cpu u_qcore_cpu (
      .clk_i, .rst_ni, .restart_i, .en_i, .flag_i,
      .pmem_addr_o, .pmem_en_o, .pmem_dt_i,
      .dmem_we_o, .dmem_addr_o, .dmem_w_dt_o, .dmem_r_dt_i,
      .port_we_o, .port_addr_o, .port_dt_o
   );

   always #4 clk_i = ~clk_i;  // 8 ns period

   //////////////////////////////////////////////////
   // Memory models
   always @(posedge clk_i) begin
      if (pmem_en_o) pmem_dt_i <= prog[pmem_addr_o];
      if (dmem_we_o) dmem[dmem_addr_o] <= dmem_w_dt_o;
      dmem_r_dt_i <= dmem[dmem_addr_o];  // Old data on a same-cycle write
   end

   // en_i alternates in random stretches when enabled
   always @(posedge clk_i) begin
      if (!en_rand) begin
         en_i <= 1'b1;
      end else if (en_left == 0) begin
         en_i    <= !en_i;
         en_left <= int'($urandom % 6);
      end else begin
         en_left <= en_left - 1;
      end
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_port(input qcore_pkg::port_addr_t exp_a, input qcore_pkg::word_t exp_d,
                             input qcore_pkg::port_addr_t got_a, input qcore_pkg::word_t got_d);
      if (exp_a !== got_a || exp_d !== got_d)
         fail_run($sformatf("Mismatch %s port write: expected %0d/%h, actual %0d/%h",
                            test_name, exp_a, exp_d, got_a, got_d));
   endtask

   task automatic check_store(input qcore_pkg::dmem_addr_t exp_a, input qcore_pkg::word_t exp_d,
                              input qcore_pkg::dmem_addr_t got_a, input qcore_pkg::word_t got_d);
      if (exp_a !== got_a || exp_d !== got_d)
         fail_run($sformatf("Mismatch %s store: expected %h/%h, actual %h/%h",
                            test_name, exp_a, exp_d, got_a, got_d));
   endtask

   // Sampled mid-cycle, away from the driving edge
   always @(negedge clk_i) begin
      if (checking && port_we_o) begin
         if (exp_port_a.size() == 0)
            fail_run($sformatf("%s: port write with none expected", test_name));
         else
            check_port(exp_port_a.pop_front(), exp_port_d.pop_front(), port_addr_o, port_dt_o);
      end
      if (checking && dmem_we_o) begin
         if (exp_st_a.size() == 0)
            fail_run($sformatf("%s: store with none expected", test_name));
         else
            check_store(exp_st_a.pop_front(), exp_st_d.pop_front(), dmem_addr_o, dmem_w_dt_o);
      end
   end

   // Watchdog
   always @(posedge clk_i) cyc <= cyc + 1;
   always @(negedge clk_i) begin
      if (cyc > budget)
         fail_run($sformatf("%s timed out with %0d port writes and %0d stores missing",
                            test_name, exp_port_a.size(), exp_st_a.size()));
   end

   task automatic pulse_restart();
      @(posedge clk_i);
      restart_i <= 1'b1;
      @(posedge clk_i);
      restart_i <= 1'b0;
   endtask

   task automatic run_prog(input string name, input logic flag, input logic rnd_en, input int pre);
      int steps;
      test_name = name;
      checking  = 1'b0;
      @(posedge clk_i);
      flag_i <= flag;
      if (pre > 0) begin  // Partial run before the real one
         budget = cyc + pre + 20;
         pulse_restart();
         repeat (pre) @(posedge clk_i);
      end
      pulse_restart();
      checking = 1'b1;
      @(negedge clk_i);
      ref_dmem = dmem;
      steps    = run_ref(flag);
      budget   = cyc + 20 * steps + 40;
      en_rand  = rnd_en;
      while (exp_port_a.size() != 0 || exp_st_a.size() != 0) @(posedge clk_i);
      en_rand = 1'b0;
      repeat (16) @(posedge clk_i);  // Catch extra writes
   endtask

   //////////////////////////////////////////////////
   // Programs
   task automatic build_alu();
      new_prog();
      for (int k = 0; k < 8; k++) begin
         load_imm(4'd1, 16'($urandom));
         load_imm(4'd2, 16'($urandom));
         emit(encode(qcore_pkg::PORT_WR, qcore_pkg::ALWAYS, qcore_pkg::alu_op_e'(3'(k)),
                     1'b0, 1'b0, 4'(k), 4'd1, 4'd2, 16'd0));
      end
      halt_here();
   endtask

   task automatic build_chain();
      qcore_pkg::reg_addr_t rd, prev;
      new_prog();
      prev = 4'd1;
      // Port 15 shows r1 before its load, zero after a restart
      emit(encode(qcore_pkg::PORT_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b1, 1'b0,
                  4'd15, prev, 4'd0, 16'd0));
      load_imm(prev, 16'($urandom));
      for (int k = 0; k < 8; k++) begin
         rd = 4'(2 + k % 3);
         emit(encode(qcore_pkg::REG_WR, qcore_pkg::ALWAYS,
                     qcore_pkg::alu_op_e'(3'($urandom % 5)), 1'b1, 1'b0, rd, prev, 4'd0,
                     16'($urandom)));
         emit(encode(qcore_pkg::PORT_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b1, 1'b0,
                     4'(k), rd, 4'd0, 16'd0));
         prev = rd;
      end
      halt_here();
   endtask

   task automatic build_mem();
      logic [15:0] off;
      new_prog();
      load_imm(4'd1, 16'($urandom % 128));  // Base
      for (int k = 0; k < 6; k++) begin
         off = 16'($urandom % 64);
         load_imm(4'd2, 16'($urandom));
         emit(encode(qcore_pkg::MEM_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0, 1'b0,
                     4'd0, 4'd1, 4'd2, off));
         emit(encode(qcore_pkg::REG_LD, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b0, 1'b0,
                     4'd3, 4'd1, 4'd0, off));
         emit(encode(qcore_pkg::PORT_WR, qcore_pkg::ALWAYS, qcore_pkg::PASS_B, 1'b0, 1'b0,
                     4'(k), 4'd0, 4'd3, 16'd0));
      end
      halt_here();
   endtask

   task automatic build_loops();
      int n, top;
      new_prog();
      n = 3 + int'($urandom % 4);
      load_imm(4'd1, 16'(n));
      top = plen;  // Count down on NZ
      emit(encode(qcore_pkg::REG_WR, qcore_pkg::ALWAYS, qcore_pkg::SUB, 1'b1, 1'b1,
                  4'd1, 4'd1, 4'd0, 16'd1));
      emit(encode(qcore_pkg::PORT_WR, qcore_pkg::ALWAYS, qcore_pkg::PASS_B, 1'b0, 1'b0,
                  4'd1, 4'd0, 4'd1, 16'd0));
      emit(encode(qcore_pkg::BRANCH, qcore_pkg::NZ, qcore_pkg::ADD, 1'b0, 1'b0,
                  4'd0, 4'd0, 4'd0, 16'(top)));
      load_imm(4'd2, 16'(-n));
      top = plen;  // Count up on LT
      emit(encode(qcore_pkg::REG_WR, qcore_pkg::ALWAYS, qcore_pkg::ADD, 1'b1, 1'b1,
                  4'd2, 4'd2, 4'd0, 16'd1));
      emit(encode(qcore_pkg::PORT_WR, qcore_pkg::EQ, qcore_pkg::PASS_B, 1'b0, 1'b0,
                  4'd2, 4'd0, 4'd2, 16'd0));
      emit(encode(qcore_pkg::BRANCH, qcore_pkg::LT, qcore_pkg::ADD, 1'b0, 1'b0,
                  4'd0, 4'd0, 4'd0, 16'(top)));
      emit(encode(qcore_pkg::PORT_WR, qcore_pkg::FLAG, qcore_pkg::PASS_B, 1'b1, 1'b0,
                  4'd3, 4'd0, 4'd0, 16'h0033));
      emit(encode(qcore_pkg::PORT_WR, qcore_pkg::NFLAG, qcore_pkg::PASS_B, 1'b1, 1'b0,
                  4'd4, 4'd0, 4'd0, 16'h0044));
      emit(encode(qcore_pkg::BRANCH, qcore_pkg::FLAG, qcore_pkg::ADD, 1'b0, 1'b0,
                  4'd0, 4'd0, 4'd0, 16'(plen + 2)));
      emit(encode(qcore_pkg::PORT_WR, qcore_pkg::ALWAYS, qcore_pkg::PASS_B, 1'b1, 1'b0,
                  4'd5, 4'd0, 4'd0, 16'h8055));
      halt_here();
   endtask

   initial begin
      void'($urandom(74));
      clk_i = 1'b0;
      rst_ni = 1'b0;
      restart_i = 1'b0;
      en_i = 1'b1;
      flag_i = 1'b0;
      pmem_dt_i = '0;
      dmem_r_dt_i = '0;
      checking = 1'b0;
      en_rand = 1'b0;
      en_left = 0;
      cyc = 0;
      budget = 200;
      test_name = "reset";
      new_prog();
      for (int i = 0; i < 256; i++)
         dmem[8'(i)] = 32'(i) * 32'h9E37_79B1;
      repeat (8) @(posedge clk_i);
      rst_ni <= 1'b1;

      build_alu();
      run_prog("alu_ops", 1'b0, 1'b0, 0);
      build_chain();
      run_prog("dep_chain", 1'b0, 1'b0, 0);
      build_mem();
      run_prog("store_load", 1'b0, 1'b0, 0);
      build_loops();
      run_prog("loops_flag0", 1'b0, 1'b0, 0);
      run_prog("loops_flag1", 1'b1, 1'b0, 0);
      build_mem();
      run_prog("store_load_en", 1'b0, 1'b1, 0);
      build_loops();
      run_prog("loops_en", 1'b1, 1'b1, 0);
      build_chain();
      run_prog("restart", 1'b0, 1'b0, 10 + int'($urandom % 20));

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+common
+incdir+sim
common/qcore_pkg.sv
core/qcore_fetch.sv
core/qcore_decode.sv
core/qcore_hazard.sv
core/qcore_reg_bank.sv
core/qcore_execute.sv
verilog/qcore_cpu.sv
sim/qcore_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= qcore_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard common/*.svh sim/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG); grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
